//--- Bender.yml
# slow-control and analog I/O core
package:
  name: rp_core

sources:
  # package first, then leaf modules, then the top level
  - rp_pkg.sv
  - sys_bus_decoder.sv
  - hk_regs.sv
  - analog_regs.sv
  - analog_io.sv
  - pwm_cfg_regs.sv
  - pwm_channel.sv
  - rp_top.sv

  # self-checking testbench, top module tb_rp_top
  - target: test
    files:
      - tb_rp_top.sv

//--- analog_io.sv
`timescale 1ns/10ps
// analog I/O path
// pin registers for ADC and DAC codes, neg-slope offset binary to and
// from two's complement, digital loop from DAC levels back to samples
module analog_io (
  input  logic                adc_clk,
  input  logic                rst_n_i,
  input  rp_pkg::raw_sample_t adc_dat_a_i,
  input  rp_pkg::raw_sample_t adc_dat_b_i,
  input  logic                digital_loop_i,
  input  rp_pkg::sample_t     dac_lvl_a_i,
  input  rp_pkg::sample_t     dac_lvl_b_i,
  output rp_pkg::sample_t     adc_a_o,
  output rp_pkg::sample_t     adc_b_o,
  output rp_pkg::raw_sample_t dac_dat_a_o,
  output rp_pkg::raw_sample_t dac_dat_b_o
);

  rp_pkg::raw_sample_t adc_raw_a;  // ADC codes at the pin boundary
  rp_pkg::raw_sample_t adc_raw_b;

  // keep MSB, invert the rest
  // same mapping in both directions
  function automatic logic [$bits(rp_pkg::sample_t)-1:0] slope_conv(
    input logic [$bits(rp_pkg::sample_t)-1:0] code
  );
    return {code[$bits(code)-1], ~code[$bits(code)-2:0]};
  endfunction

  ////////////////////////////////////////////////////////////
  // ADC side
  ////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    adc_raw_a <= adc_dat_a_i;
    adc_raw_b <= adc_dat_b_i;
  end

  // loop on: samples come straight from the DAC levels
  assign adc_a_o = digital_loop_i ? dac_lvl_a_i : slope_conv(adc_raw_a);
  assign adc_b_o = digital_loop_i ? dac_lvl_b_i : slope_conv(adc_raw_b);

  ////////////////////////////////////////////////////////////
  // DAC side
  ////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      dac_dat_a_o <= slope_conv('0);  // level 0 -> 14'h1FFF on the pins
      dac_dat_b_o <= slope_conv('0);
    end
    else
    begin
      dac_dat_a_o <= slope_conv(dac_lvl_a_i);
      dac_dat_b_o <= slope_conv(dac_lvl_b_i);
    end
  end

endmodule

//--- analog_regs.sv
`timescale 1ns/10ps
// analog register slave
// DAC level registers plus readback of the converted ADC samples
module analog_regs (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  rp_pkg::sys_req_t req_i,
  output rp_pkg::sys_rsp_t rsp_o,
  output rp_pkg::sample_t  dac_lvl_a_o,
  output rp_pkg::sample_t  dac_lvl_b_o,
  input  rp_pkg::sample_t  adc_a_i,
  input  rp_pkg::sample_t  adc_b_i
);

  logic [rp_pkg::REGION_LSB-1:0] ofs;
  logic                          wr_hit;  // writable offset
  logic                          rd_hit;  // readable offset
  rp_pkg::bus_data_t             rd_data;

  // sign-extend a sample to a bus word
  function automatic rp_pkg::bus_data_t sext(input rp_pkg::sample_t s);
    return {{($bits(rp_pkg::bus_data_t) - $bits(rp_pkg::sample_t)){s[$bits(s)-1]}}, s};
  endfunction

  assign ofs = req_i.addr[rp_pkg::REGION_LSB-1:0];

  always_comb
  begin
    wr_hit  = 1'b0;
    rd_hit  = 1'b1;
    rd_data = '0;
    case (ofs)
      rp_pkg::AN_DAC_A_OFS:
      begin
        wr_hit  = 1'b1;
        rd_data = sext(dac_lvl_a_o);
      end
      rp_pkg::AN_DAC_B_OFS:
      begin
        wr_hit  = 1'b1;
        rd_data = sext(dac_lvl_b_o);
      end
      rp_pkg::AN_ADC_A_OFS: rd_data = sext(adc_a_i);  // read only
      rp_pkg::AN_ADC_B_OFS: rd_data = sext(adc_b_i);
      default:              rd_hit  = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // DAC levels, low 14 bits of the write word
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      dac_lvl_a_o <= '0;
      dac_lvl_b_o <= '0;
    end
    else if (req_i.wen)
    begin
      case (ofs)
        rp_pkg::AN_DAC_A_OFS: dac_lvl_a_o <= req_i.wdata[$bits(rp_pkg::sample_t)-1:0];
        rp_pkg::AN_DAC_B_OFS: dac_lvl_b_o <= req_i.wdata[$bits(rp_pkg::sample_t)-1:0];
        default: ;
      endcase
    end
  end

  // sample offsets are not writable -> err
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      rsp_o <= '0;
    else
    begin
      rsp_o.ack   <= req_i.wen | req_i.ren;
      rsp_o.err   <= (req_i.wen & ~wr_hit) | (req_i.ren & ~rd_hit);
      rsp_o.rdata <= (req_i.ren & rd_hit) ? rd_data : '0;
    end
  end

endmodule

//--- flist.f
rp_pkg.sv
sys_bus_decoder.sv
hk_regs.sv
analog_regs.sv
analog_io.sv
pwm_cfg_regs.sv
pwm_channel.sv
rp_top.sv
tb_rp_top.sv

//--- hk_regs.sv
`timescale 1ns/10ps
// housekeeping register slave
// read-only ID, digital-loop switch and LED register
module hk_regs (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  rp_pkg::sys_req_t req_i,
  output rp_pkg::sys_rsp_t rsp_o,
  output logic             digital_loop_o,
  output rp_pkg::led_t     led_o
);

  logic [rp_pkg::REGION_LSB-1:0] ofs;  // offset inside the region
  logic                          hit;
  rp_pkg::bus_data_t             rd_data;

  assign ofs = req_i.addr[rp_pkg::REGION_LSB-1:0];

  // read mux and offset decode
  always_comb
  begin
    hit     = 1'b1;
    rd_data = '0;
    case (ofs)
      rp_pkg::HK_ID_OFS:   rd_data = rp_pkg::HK_ID;
      rp_pkg::HK_LOOP_OFS: rd_data = rp_pkg::bus_data_t'(digital_loop_o);
      rp_pkg::HK_LED_OFS:  rd_data = rp_pkg::bus_data_t'(led_o);
      default:             hit     = 1'b0;  // unmapped
    endcase
  end

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      digital_loop_o <= 1'b0;
      led_o          <= '0;
    end
    else if (req_i.wen)
    begin
      case (ofs)
        rp_pkg::HK_LOOP_OFS: digital_loop_o <= req_i.wdata[0];
        rp_pkg::HK_LED_OFS:  led_o <= req_i.wdata[$bits(rp_pkg::led_t)-1:0];
        default: ;  // ID write ignored
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // response, one cycle after the strobe
  ////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      rsp_o <= '0;
    else
    begin
      rsp_o.ack   <= req_i.wen | req_i.ren;
      rsp_o.err   <= (req_i.wen | req_i.ren) & ~hit;
      rsp_o.rdata <= (req_i.ren & hit) ? rd_data : '0;
    end
  end

  // master never reads and writes at once
  a_no_rw_overlap : assert property (
    @(posedge adc_clk) disable iff (!rst_n_i) !(req_i.wen && req_i.ren)
  );

endmodule

//--- pwm_cfg_regs.sv
`timescale 1ns/10ps
// PWM configuration register slave
// four 24-bit channel words, duty in [23:16] and dither in [15:0]
module pwm_cfg_regs (
  input  logic                                     adc_clk,
  input  logic                                     rst_n_i,
  input  rp_pkg::sys_req_t                         req_i,
  output rp_pkg::sys_rsp_t                         rsp_o,
  output rp_pkg::pwm_cfg_t [rp_pkg::NUM_PWM-1:0]   pwm_cfg_o
);

  logic [rp_pkg::REGION_LSB-1:0]      ofs;
  logic [$clog2(rp_pkg::NUM_PWM)-1:0] sel;  // channel addressed
  logic                               hit;

  assign ofs = req_i.addr[rp_pkg::REGION_LSB-1:0];

  // offset -> channel index
  always_comb
  begin
    hit = 1'b1;
    sel = 2'd0;
    case (ofs)
      rp_pkg::PWM_CFG_OFS_A: sel = 2'd0;
      rp_pkg::PWM_CFG_OFS_B: sel = 2'd1;
      rp_pkg::PWM_CFG_OFS_C: sel = 2'd2;
      rp_pkg::PWM_CFG_OFS_D: sel = 2'd3;
      default:               hit = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // config storage
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      pwm_cfg_o <= '0;
    else if (req_i.wen && hit)
      pwm_cfg_o[sel] <= req_i.wdata[$bits(rp_pkg::pwm_cfg_t)-1:0];  // top byte dropped
  end

  // response
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      rsp_o <= '0;
    else
    begin
      rsp_o.ack   <= req_i.wen | req_i.ren;
      rsp_o.err   <= (req_i.wen | req_i.ren) & ~hit;
      rsp_o.rdata <= (req_i.ren & hit) ? rp_pkg::bus_data_t'(pwm_cfg_o[sel]) : '0;
    end
  end

endmodule

//--- pwm_channel.sv
`timescale 1ns/10ps
// dithered 8-bit PWM DAC channel
// 256-tick period, 16-period dither frame, config taken at frame start
module pwm_channel (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  rp_pkg::pwm_cfg_t cfg_i,
  output logic             pwm_o
);

  logic [$clog2(rp_pkg::PWM_STEPS)-1:0]     tick;   // position in period
  logic [$clog2(rp_pkg::PWM_SUBCYCLES)-1:0] sub;    // period in frame
  rp_pkg::pwm_cfg_t                         cfg_q;  // latched config
  rp_pkg::pwm_cfg_t                         cfg_use;
  logic [$clog2(rp_pkg::PWM_STEPS)-1:0]     duty;
  logic                                     dither_bit;
  logic [$clog2(rp_pkg::PWM_STEPS):0]       level;  // duty + dither, up to 256
  logic                                     frame_start;

  assign frame_start = (tick == '0) && (sub == '0);

  // the first tick of a frame already runs on the new config
  assign cfg_use    = frame_start ? cfg_i : cfg_q;
  assign duty       = cfg_use[rp_pkg::PWM_SUBCYCLES +: $clog2(rp_pkg::PWM_STEPS)];
  assign dither_bit = cfg_use[sub];  // dither bit k in subcycle k
  assign level      = {1'b0, duty} + {{$clog2(rp_pkg::PWM_STEPS){1'b0}}, dither_bit};

  ////////////////////////////////////////////////////////////
  // counters, config latch, registered output
  ////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      tick  <= '0;
      sub   <= '0;
      cfg_q <= '0;
      pwm_o <= 1'b0;
    end
    else
    begin
      tick <= tick + 1'b1;  // wraps every PWM_STEPS
      if (&tick)
        sub <= sub + 1'b1;  // next period of the frame
      if (frame_start)
        cfg_q <= cfg_i;
      pwm_o <= ({1'b0, tick} < level);  // high while tick below level
    end
  end

  // register writes land any time, the channel only picks them up per frame
  a_cfg_at_frame : assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    (cfg_q != $past(cfg_q)) |-> $past(frame_start)
  );

endmodule

//--- rp_pkg.sv
// slow-control core shared definitions
// bus request/response structs, sample types, region map, register offsets
package rp_pkg;

  ////////////////////////////////////////////////////////////
  // system bus region map
  ////////////////////////////////////////////////////////////
  localparam int unsigned NUM_REGIONS = 8;
  localparam int unsigned REGION_LSB  = 20;   // addr[22:20] picks the region
  localparam int unsigned REGION_BITS = 3;

  localparam int unsigned HK_REGION     = 0;
  localparam int unsigned ANALOG_REGION = 1;
  localparam int unsigned PWM_REGION    = 4;

  // regions with a slave behind them, the rest ack at once
  localparam logic [NUM_REGIONS-1:0] REGION_MASK =
    (1 << HK_REGION) | (1 << ANALOG_REGION) | (1 << PWM_REGION);

  localparam logic [31:0] HK_ID = 32'h5250_0100;  // "RP", rev 1.0

  // offsets below the region field
  localparam logic [REGION_LSB-1:0] HK_ID_OFS     = 20'h00;
  localparam logic [REGION_LSB-1:0] HK_LOOP_OFS   = 20'h04;
  localparam logic [REGION_LSB-1:0] HK_LED_OFS    = 20'h08;
  localparam logic [REGION_LSB-1:0] AN_DAC_A_OFS  = 20'h00;
  localparam logic [REGION_LSB-1:0] AN_DAC_B_OFS  = 20'h04;
  localparam logic [REGION_LSB-1:0] AN_ADC_A_OFS  = 20'h08;
  localparam logic [REGION_LSB-1:0] AN_ADC_B_OFS  = 20'h0C;
  localparam logic [REGION_LSB-1:0] PWM_CFG_OFS_A = 20'h00;
  localparam logic [REGION_LSB-1:0] PWM_CFG_OFS_B = 20'h04;
  localparam logic [REGION_LSB-1:0] PWM_CFG_OFS_C = 20'h08;
  localparam logic [REGION_LSB-1:0] PWM_CFG_OFS_D = 20'h0C;

  ////////////////////////////////////////////////////////////
  // slow PWM DAC
  ////////////////////////////////////////////////////////////
  localparam int unsigned NUM_PWM       = 4;
  localparam int unsigned PWM_STEPS     = 256;  // ticks per period
  localparam int unsigned PWM_SUBCYCLES = 16;   // periods per dither frame

  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;
  typedef logic [13:0] raw_sample_t;  // neg-slope offset binary, pin format
  typedef logic [13:0] sample_t;      // two's complement
  typedef logic [23:0] pwm_cfg_t;     // [23:16] duty, [15:0] dither
  typedef logic [7:0]  led_t;

  typedef struct packed {
    bus_addr_t addr;
    bus_data_t wdata;
    logic      wen;   // one-cycle strobes
    logic      ren;
  } sys_req_t;

  typedef struct packed {
    bus_data_t rdata;
    logic      ack;
    logic      err;
  } sys_rsp_t;

endpackage

//--- rp_top.sv
`timescale 1ns/10ps
// slow-control and analog I/O core top level
// bus decoder, register slaves, analog pin path and four PWM channels
module rp_top (
  input  logic                        adc_clk,
  input  logic                        rst_n_i,
  input  rp_pkg::sys_req_t            sys_req_i,
  output rp_pkg::sys_rsp_t            sys_rsp_o,
  input  rp_pkg::raw_sample_t         adc_dat_a_i,
  input  rp_pkg::raw_sample_t         adc_dat_b_i,
  output rp_pkg::raw_sample_t         dac_dat_a_o,
  output rp_pkg::raw_sample_t         dac_dat_b_o,
  output logic [rp_pkg::NUM_PWM-1:0]  pwm_o,
  output rp_pkg::led_t                led_o
);

  rp_pkg::sys_req_t                       region_req [rp_pkg::NUM_REGIONS];
  rp_pkg::sys_rsp_t                       region_rsp [rp_pkg::NUM_REGIONS];
  logic                                   digital_loop;
  rp_pkg::sample_t                        dac_lvl_a;  // bus -> DAC path
  rp_pkg::sample_t                        dac_lvl_b;
  rp_pkg::sample_t                        adc_a;      // ADC path -> bus
  rp_pkg::sample_t                        adc_b;
  rp_pkg::pwm_cfg_t [rp_pkg::NUM_PWM-1:0] pwm_cfg;

  ////////////////////////////////////////////////////////////
  // system bus
  ////////////////////////////////////////////////////////////
  sys_bus_decoder i_sys_bus_decoder (
    .adc_clk   (adc_clk),
    .sys_req_i (sys_req_i),
    .sys_rsp_o (sys_rsp_o),
    .reg_req_o (region_req),
    .reg_rsp_i (region_rsp)
  );

  // empty regions, the decoder answers for them
  for (genvar r = 0; r < rp_pkg::NUM_REGIONS; r++)
  begin : g_empty
    if (!rp_pkg::REGION_MASK[r])
    begin : g_tie
      assign region_rsp[r] = '0;
    end
  end

  hk_regs i_hk_regs (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .req_i          (region_req[rp_pkg::HK_REGION]),
    .rsp_o          (region_rsp[rp_pkg::HK_REGION]),
    .digital_loop_o (digital_loop),
    .led_o          (led_o)
  );

  analog_regs i_analog_regs (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .req_i       (region_req[rp_pkg::ANALOG_REGION]),
    .rsp_o       (region_rsp[rp_pkg::ANALOG_REGION]),
    .dac_lvl_a_o (dac_lvl_a),
    .dac_lvl_b_o (dac_lvl_b),
    .adc_a_i     (adc_a),
    .adc_b_i     (adc_b)
  );

  pwm_cfg_regs i_pwm_cfg_regs (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .req_i     (region_req[rp_pkg::PWM_REGION]),
    .rsp_o     (region_rsp[rp_pkg::PWM_REGION]),
    .pwm_cfg_o (pwm_cfg)
  );

  ////////////////////////////////////////////////////////////
  // analog pins and slow PWM DACs
  ////////////////////////////////////////////////////////////
  analog_io i_analog_io (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .dac_lvl_a_i    (dac_lvl_a),
    .dac_lvl_b_i    (dac_lvl_b),
    .adc_a_o        (adc_a),
    .adc_b_o        (adc_b),
    .dac_dat_a_o    (dac_dat_a_o),
    .dac_dat_b_o    (dac_dat_b_o)
  );

  for (genvar k = 0; k < rp_pkg::NUM_PWM; k++)
  begin : g_pwm
    pwm_channel i_pwm_channel (
      .adc_clk (adc_clk),
      .rst_n_i (rst_n_i),
      .cfg_i   (pwm_cfg[k]),
      .pwm_o   (pwm_o[k])  // straight to the pin
    );
  end

endmodule

//--- sys_bus_decoder.sv
`timescale 1ns/10ps
// system bus region decoder
// fans the request out to eight regions by addr[22:20] and muxes
// the selected response back, empty regions ack in the strobe cycle
module sys_bus_decoder (
  input  logic             adc_clk,
  input  rp_pkg::sys_req_t sys_req_i,
  output rp_pkg::sys_rsp_t sys_rsp_o,
  output rp_pkg::sys_req_t reg_req_o [rp_pkg::NUM_REGIONS],
  input  rp_pkg::sys_rsp_t reg_rsp_i [rp_pkg::NUM_REGIONS]
);

  logic [rp_pkg::REGION_BITS-1:0] region;     // region field of the address
  logic [rp_pkg::NUM_REGIONS-1:0] region_cs;  // one-hot select
  rp_pkg::sys_rsp_t               rsp_all [rp_pkg::NUM_REGIONS];

  assign region = sys_req_i.addr[rp_pkg::REGION_LSB +: rp_pkg::REGION_BITS];

  ////////////////////////////////////////////////////////////
  // per-region request gating and response source
  ////////////////////////////////////////////////////////////
  for (genvar r = 0; r < rp_pkg::NUM_REGIONS; r++)
  begin : g_region
    assign region_cs[r] = (region == r);

    // addr and wdata go to everyone, only strobes are gated
    assign reg_req_o[r] = '{
      addr:  sys_req_i.addr,
      wdata: sys_req_i.wdata,
      wen:   sys_req_i.wen & region_cs[r],
      ren:   sys_req_i.ren & region_cs[r]
    };

    if (rp_pkg::REGION_MASK[r])
    begin : g_slave
      assign rsp_all[r] = reg_rsp_i[r];
    end
    else
    begin : g_empty
      // no slave here, answer right away with zero data
      assign rsp_all[r] = '{
        rdata: '0,
        ack:   reg_req_o[r].wen | reg_req_o[r].ren,
        err:   1'b0
      };
    end
  end

  assign sys_rsp_o = rsp_all[region];  // address held until ack

  // a slave flagging err must ack in the same cycle
  a_err_with_ack : assert property (
    @(posedge adc_clk) sys_rsp_o.err |-> sys_rsp_o.ack
  );

endmodule

//--- tb_rp_top.sv
`timescale 1ns/10ps
// testbench for the slow-control core
// table of bus accesses, analog path checks with random pin codes,
// PWM average over one dither frame
module tb_rp_top;

  localparam int CLK_PERIOD   = 40;
  localparam int ACK_LIMIT    = 8;      // cycles to wait for ack
  localparam int FRAME_CYCLES = 4096;   // 256 ticks x 16 subcycles
  localparam int MAX_CYCLES   = 20000;  // ~60 accesses + 3 PWM frames, with margin

  typedef struct packed {
    logic                          write;
    logic [2:0]                    region;
    logic [rp_pkg::REGION_LSB-1:0] ofs;
    rp_pkg::bus_data_t             wdata;
    rp_pkg::bus_data_t             exp_rdata;  // reads only
    logic                          exp_err;
  } table_entry_t;

  logic                              adc_clk;
  logic                              rst_n_i;
  rp_pkg::sys_req_t                  sys_req;
  rp_pkg::sys_rsp_t                  sys_rsp;
  rp_pkg::raw_sample_t               adc_dat_a;
  rp_pkg::raw_sample_t               adc_dat_b;
  rp_pkg::raw_sample_t               dac_dat_a;
  rp_pkg::raw_sample_t               dac_dat_b;
  logic [rp_pkg::NUM_PWM-1:0]        pwm;
  rp_pkg::led_t                      led;

  table_entry_t                      stim_table [64];
  int                                num_entries;
  rp_pkg::pwm_cfg_t                  pwm_cfg_val [rp_pkg::NUM_PWM];
  int                                pwm_high [rp_pkg::NUM_PWM];
  logic [31:0]                       rng;
  int                                errors;
  int                                checks;
  int                                cycle_cnt;

  rp_top i_rp_top (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .sys_req_i   (sys_req),
    .sys_rsp_o   (sys_rsp),
    .adc_dat_a_i (adc_dat_a),
    .adc_dat_b_i (adc_dat_b),
    .dac_dat_a_o (dac_dat_a),
    .dac_dat_b_o (dac_dat_b),
    .pwm_o       (pwm),
    .led_o       (led)
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #(CLK_PERIOD/2) adc_clk = ~adc_clk;
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int popcount16(input logic [15:0] v);
    int n;
    n = 0;
    for (int i = 0; i < 16; i++)
      n += v[i];
    return n;
  endfunction

  // region in bits 22..20, offset below
  function automatic rp_pkg::bus_addr_t make_addr(input logic [2:0] region,
                                                  input logic [19:0] ofs);
    return {9'd0, region, ofs};
  endfunction

  // sample model: pin code keeps MSB, low 13 bits flipped, then sign-extended
  function automatic rp_pkg::bus_data_t pin_to_word(input logic [13:0] code);
    logic [13:0] s;
    s = code ^ 14'h1FFF;
    return {{18{s[13]}}, s};
  endfunction

  task automatic add_entry(input logic write, input int unsigned region,
                           input logic [19:0] ofs, input rp_pkg::bus_data_t wdata,
                           input rp_pkg::bus_data_t exp_rdata, input logic exp_err);
    stim_table[num_entries].write     = write;
    stim_table[num_entries].region    = 3'(region);
    stim_table[num_entries].ofs       = ofs;
    stim_table[num_entries].wdata     = wdata;
    stim_table[num_entries].exp_rdata = exp_rdata;
    stim_table[num_entries].exp_err   = exp_err;
    num_entries++;
  endtask

  // one strobe cycle, then wait for ack; rsp sampled on the falling edge
  task automatic bus_access(input logic write, input rp_pkg::bus_addr_t addr,
                            input rp_pkg::bus_data_t wdata,
                            output rp_pkg::bus_data_t rdata, output logic err);
    int   waited;
    logic got_ack;
    waited  = 0;
    got_ack = 1'b0;
    rdata   = '0;
    err     = 1'b0;
    @(negedge adc_clk);
    sys_req.addr  = addr;
    sys_req.wdata = wdata;
    sys_req.wen   = write;
    sys_req.ren   = !write;
    while (!got_ack && waited < ACK_LIMIT)
    begin
      @(negedge adc_clk);
      waited++;
      if (sys_rsp.ack)
      begin
        got_ack = 1'b1;
        rdata   = sys_rsp.rdata;
        err     = sys_rsp.err;
      end
      sys_req.wen = 1'b0;  // strobe only one cycle
      sys_req.ren = 1'b0;
    end
    if (!got_ack)
    begin
      $display("no ack on the bus for address %h at %0t", addr, $time);
      errors++;
    end
  endtask

  // write a register and expect a clean ack
  task automatic write_reg(input int unsigned region, input logic [19:0] ofs,
                           input rp_pkg::bus_data_t wdata);
    rp_pkg::bus_data_t rdata;
    logic              err;
    bus_access(1'b1, make_addr(3'(region), ofs), wdata, rdata, err);
    checks++;
    if (err)
    begin
      $display("CHECK FAILED at %0t: write to region %0d ofs %h got err",
               $time, region, ofs);
      errors++;
    end
  endtask

  task automatic read_sample(input logic [19:0] ofs, input rp_pkg::bus_data_t exp);
    rp_pkg::bus_data_t rdata;
    logic              err;
    bus_access(1'b0, make_addr(3'(rp_pkg::ANALOG_REGION), ofs), '0, rdata, err);
    checks++;
    if (err || rdata !== exp)
    begin
      $display("CHECK FAILED at %0t: sample ofs %h read %h err %b, expected %h",
               $time, ofs, rdata, err, exp);
      errors++;
    end
  endtask

  task automatic build_table;
    pwm_cfg_val[0] = 24'h00_0000;  // always low
    pwm_cfg_val[1] = 24'hFF_FFFF;  // always high
    pwm_cfg_val[2] = 24'h40_A5A5;
    pwm_cfg_val[3] = 24'h81_0F01;
    num_entries = 0;
    // housekeeping
    add_entry(0, rp_pkg::HK_REGION, rp_pkg::HK_ID_OFS, 0, rp_pkg::HK_ID, 0);
    add_entry(1, rp_pkg::HK_REGION, rp_pkg::HK_ID_OFS, 32'hDEAD_BEEF, 0, 0);
    add_entry(0, rp_pkg::HK_REGION, rp_pkg::HK_ID_OFS, 0, rp_pkg::HK_ID, 0);
    add_entry(1, rp_pkg::HK_REGION, rp_pkg::HK_LED_OFS, 32'h1234_56A5, 0, 0);
    add_entry(0, rp_pkg::HK_REGION, rp_pkg::HK_LED_OFS, 0, 32'h0000_00A5, 0);
    add_entry(1, rp_pkg::HK_REGION, rp_pkg::HK_LED_OFS, 32'h0000_003C, 0, 0);
    add_entry(0, rp_pkg::HK_REGION, rp_pkg::HK_LED_OFS, 0, 32'h0000_003C, 0);
    add_entry(1, rp_pkg::HK_REGION, rp_pkg::HK_LOOP_OFS, 32'h1, 0, 0);
    add_entry(0, rp_pkg::HK_REGION, rp_pkg::HK_LOOP_OFS, 0, 32'h1, 0);
    add_entry(1, rp_pkg::HK_REGION, rp_pkg::HK_LOOP_OFS, 32'h0, 0, 0);
    add_entry(0, rp_pkg::HK_REGION, rp_pkg::HK_LOOP_OFS, 0, 32'h0, 0);
    // DAC levels, low 14 bits kept, readback sign-extended
    add_entry(1, rp_pkg::ANALOG_REGION, rp_pkg::AN_DAC_A_OFS, 32'h0000_1234, 0, 0);
    add_entry(0, rp_pkg::ANALOG_REGION, rp_pkg::AN_DAC_A_OFS, 0, 32'h0000_1234, 0);
    add_entry(1, rp_pkg::ANALOG_REGION, rp_pkg::AN_DAC_B_OFS, 32'h0000_2ABC, 0, 0);
    add_entry(0, rp_pkg::ANALOG_REGION, rp_pkg::AN_DAC_B_OFS, 0, 32'hFFFF_EABC, 0);
    add_entry(1, rp_pkg::ANALOG_REGION, rp_pkg::AN_DAC_A_OFS, 32'hFFFF_0155, 0, 0);
    add_entry(0, rp_pkg::ANALOG_REGION, rp_pkg::AN_DAC_A_OFS, 0, 32'h0000_0155, 0);
    // PWM configs, top byte of the write word dropped
    for (int k = 0; k < rp_pkg::NUM_PWM; k++)
    begin
      add_entry(1, rp_pkg::PWM_REGION, 20'(4 * k), {8'hAB, pwm_cfg_val[k]}, 0, 0);
      add_entry(0, rp_pkg::PWM_REGION, 20'(4 * k), 0, {8'h00, pwm_cfg_val[k]}, 0);
    end
    // unmapped offsets and read-only samples
    add_entry(0, rp_pkg::HK_REGION, 20'h0C, 0, 0, 1);
    add_entry(1, rp_pkg::HK_REGION, 20'h10, 32'h5, 0, 1);
    add_entry(0, rp_pkg::ANALOG_REGION, 20'h10, 0, 0, 1);
    add_entry(1, rp_pkg::ANALOG_REGION, rp_pkg::AN_ADC_A_OFS, 32'h77, 0, 1);
    add_entry(1, rp_pkg::ANALOG_REGION, rp_pkg::AN_ADC_B_OFS, 32'h77, 0, 1);
    add_entry(0, rp_pkg::PWM_REGION, 20'h10, 0, 0, 1);
    add_entry(1, rp_pkg::PWM_REGION, 20'h40, 32'h1, 0, 1);
    // empty regions
    add_entry(0, 2, 20'h00, 0, 0, 0);
    add_entry(0, 3, 20'h04, 0, 0, 0);
    add_entry(0, 5, 20'h08, 0, 0, 0);
    add_entry(1, 5, 20'h00, 32'hFFFF_FFFF, 0, 0);
    add_entry(0, 6, 20'h0C, 0, 0, 0);
    add_entry(0, 7, 20'h00, 0, 0, 0);
  endtask

  ////////////////////////////////////////////////////////////
  // run limit
  ////////////////////////////////////////////////////////////
  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES)
    begin
      @(posedge adc_clk);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial
  begin : main
    table_entry_t      e;
    rp_pkg::bus_data_t rdata;
    logic              err;
    rp_pkg::sample_t   lvl_a;
    rp_pkg::sample_t   lvl_b;
    int                exp_high;

    errors    = 0;
    checks    = 0;
    rng       = 32'h952d_631d;
    rst_n_i   = 1'b0;
    sys_req   = '0;
    adc_dat_a = '0;
    adc_dat_b = '0;
    lvl_a     = '0;
    lvl_b     = '0;
    build_table();
    repeat (5) @(negedge adc_clk);
    rst_n_i = 1'b1;

    // reset state, level 0 shows as 14'h1FFF
    checks++;
    if (dac_dat_a !== 14'h1FFF || dac_dat_b !== 14'h1FFF || pwm !== '0 || led !== '0)
    begin
      $display("CHECK FAILED at %0t: after reset dac %h/%h pwm %b led %h",
               $time, dac_dat_a, dac_dat_b, pwm, led);
      errors++;
    end

    ////////////////////////////////////////////////////////////
    // table of bus accesses
    for (int i = 0; i < num_entries; i++)
    begin
      e = stim_table[i];
      bus_access(e.write, make_addr(e.region, e.ofs), e.wdata, rdata, err);
      checks++;
      if (err !== e.exp_err || (!e.write && rdata !== e.exp_rdata))
      begin
        $display("CHECK FAILED at %0t: entry %0d region %0d ofs %h read %h err %b",
                 $time, i, e.region, e.ofs, rdata, err);
        $display("  expected %h err %b", e.exp_rdata, e.exp_err);
        errors++;
      end
      // LED pins follow the register right after ack
      if (e.write && e.region == 3'(rp_pkg::HK_REGION) && e.ofs == rp_pkg::HK_LED_OFS)
      begin
        checks++;
        if (led !== e.wdata[7:0])
        begin
          $display("CHECK FAILED at %0t: led %h, expected %h", $time, led, e.wdata[7:0]);
          errors++;
        end
      end
    end

    ////////////////////////////////////////////////////////////
    // ADC path, random pin codes held over both reads
    for (int n = 0; n < 8; n++)
    begin
      rng       = xorshift32(rng);
      adc_dat_a = rng[13:0];
      adc_dat_b = rng[29:16];
      read_sample(rp_pkg::AN_ADC_A_OFS, pin_to_word(adc_dat_a));
      read_sample(rp_pkg::AN_ADC_B_OFS, pin_to_word(adc_dat_b));
    end

    // DAC path
    for (int n = 0; n < 4; n++)
    begin
      rng   = xorshift32(rng);
      lvl_a = rng[13:0];
      lvl_b = rng[27:14];
      write_reg(rp_pkg::ANALOG_REGION, rp_pkg::AN_DAC_A_OFS, {18'd0, lvl_a});
      write_reg(rp_pkg::ANALOG_REGION, rp_pkg::AN_DAC_B_OFS, {18'd0, lvl_b});
      @(negedge adc_clk);  // pins one cycle behind the level
      checks++;
      if (dac_dat_a !== (lvl_a ^ 14'h1FFF) || dac_dat_b !== (lvl_b ^ 14'h1FFF))
      begin
        $display("CHECK FAILED at %0t: dac pins %h/%h for levels %h/%h",
                 $time, dac_dat_a, dac_dat_b, lvl_a, lvl_b);
        errors++;
      end
    end

    // digital loop, samples ignore the pins
    write_reg(rp_pkg::HK_REGION, rp_pkg::HK_LOOP_OFS, 32'h1);
    for (int n = 0; n < 4; n++)
    begin
      rng       = xorshift32(rng);
      adc_dat_a = rng[13:0];
      adc_dat_b = rng[29:16];
      read_sample(rp_pkg::AN_ADC_A_OFS, {{18{lvl_a[13]}}, lvl_a});
      read_sample(rp_pkg::AN_ADC_B_OFS, {{18{lvl_b[13]}}, lvl_b});
    end
    write_reg(rp_pkg::HK_REGION, rp_pkg::HK_LOOP_OFS, 32'h0);

    ////////////////////////////////////////////////////////////
    // PWM average over one frame
    for (int k = 0; k < rp_pkg::NUM_PWM; k++)
      write_reg(rp_pkg::PWM_REGION, 20'(4 * k), {8'h00, pwm_cfg_val[k]});
    repeat (FRAME_CYCLES) @(negedge adc_clk);  // new configs latched by now
    for (int k = 0; k < rp_pkg::NUM_PWM; k++)
      pwm_high[k] = 0;
    repeat (FRAME_CYCLES)
    begin
      @(negedge adc_clk);
      for (int k = 0; k < rp_pkg::NUM_PWM; k++)
        pwm_high[k] += pwm[k];
    end
    for (int k = 0; k < rp_pkg::NUM_PWM; k++)
    begin
      exp_high = 16 * pwm_cfg_val[k][23:16] + popcount16(pwm_cfg_val[k][15:0]);
      checks++;
      if (pwm_high[k] != exp_high)
      begin
        $display("CHECK FAILED at %0t: pwm %0d high %0d cycles, expected %0d",
                 $time, k, pwm_high[k], exp_high);
        errors++;
      end
    end

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule
